/* MmuTypes.sv */
// Sv32 types shared by the MMU blocks. Only 32-bit word accesses are described
// The satp ASID field is carried but not used for tagging
package MmuTypes;

    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    // VPN1 in [19:10], VPN0 in [9:0]
    typedef logic [19:0] vpn_t;
    // PPN1 in [21:10], PPN0 in [9:0]
    typedef logic [21:0] ppn_t;
    typedef logic [31:0] word_t;

    localparam int PteSize = 4;
    localparam int PageOffsetWidth = 12;

    typedef enum logic [1:0] {
        Load,
        Store,
        Fetch
    } AccessType;

    typedef struct packed {
        logic       MODE;
        logic [8:0] ASID;
        ppn_t       PPN;
    } SatpReg;

    typedef struct packed {
        logic [11:0] PPN1;
        logic [9:0]  PPN0;
        logic [1:0]  RSW;
        logic        D;
        logic        A;
        logic        G;
        logic        U;
        logic        X;
        logic        W;
        logic        R;
        logic        V;
    } PageTableEntry;

    typedef struct packed {
        logic dirty;
        logic user;
        logic execute;
        logic write;
        logic read;
    } TlbEntryFlags;

    typedef struct packed {
        logic         valid;
        logic         fault;
        ppn_t         pageNumber;
        TlbEntryFlags flags;
    } TlbEntry;

    typedef struct packed {
        AccessType accessType;
        vaddr_t    vaddr;
        word_t     wdata;
    } MmuRequest;

    typedef struct packed {
        word_t rdata;
        logic  fault;
    } MmuResponse;

endpackage

/* Tlb.sv */
// Direct-mapped, no ASID tag, so an address space change needs a flush
// TlbEntries must be a power of two
`timescale 1ns/1ps

module Tlb
    import MmuTypes::*;
#(
    parameter int TlbEntries = 16
) (
    input  logic    clk,
    input  logic    rst,
    input  vpn_t    lookupVpn,
    output logic    lookupHit,
    output TlbEntry lookupEntry,
    input  logic    writeEnable,
    input  vpn_t    writeKey,
    input  TlbEntry writeValue,
    input  logic    flush
);
    localparam int IndexWidth = $clog2(TlbEntries);
    localparam int TagWidth = $bits(vpn_t) - IndexWidth;

    typedef logic [IndexWidth-1:0] index_t;
    typedef logic [TagWidth-1:0] tag_t;

    logic [TlbEntries-1:0] validBits;
    tag_t tags [TlbEntries];
    TlbEntry entries [TlbEntries];
    index_t lookupIndex;
    index_t writeIndex;

    assign lookupIndex = lookupVpn[IndexWidth-1:0];
    assign writeIndex = writeKey[IndexWidth-1:0];
    assign lookupEntry = entries[lookupIndex];
    assign lookupHit = validBits[lookupIndex] && lookupEntry.valid &&
        tags[lookupIndex] == lookupVpn[$bits(vpn_t)-1:IndexWidth];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            validBits <= '0;
        end else if (writeEnable) begin
            validBits[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            tags[writeIndex] <= writeKey[$bits(vpn_t)-1:IndexWidth];
            entries[writeIndex] <= writeValue;
        end
    end
endmodule

/* PageWalker.sv */
// Two-level Sv32 walk with A/D update; no misaligned-superpage check
// A/D are written back only when the leaf permits the access
`timescale 1ns/1ps

module PageWalker
    import MmuTypes::*;
#(
    parameter int LineWidth = 128,
    parameter int MemAddrWidth = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  vpn_t                    missPage,
    input  AccessType               missAccessType,
    input  SatpReg                  satp,
    output logic                    done,
    output logic                    tlbWriteEnable,
    output vpn_t                    tlbWriteKey,
    output TlbEntry                 tlbWriteValue,
    output logic [MemAddrWidth-1:0] memAddr,
    output logic                    memReadEnable,
    output logic                    memWriteEnable,
    output logic [LineWidth-1:0]    memWriteValue,
    input  logic                    memReadDone,
    input  logic                    memWriteDone,
    input  logic [LineWidth-1:0]    memReadValue
);
    localparam int PteWidth = $bits(PageTableEntry);
    localparam int PteIndexWidth = $clog2(LineWidth / PteWidth);
    localparam int PteOffsetWidth = $clog2(PteSize);
    localparam int LineOffsetWidth = $clog2(LineWidth / 8);

    typedef enum logic [3:0] {
        Idle,
        Read1,
        Decode1,
        Write1,
        Read0,
        Decode0,
        Write0,
        TlbWrite,
        TlbWriteFault
    } State;

    State state;
    logic levelOne;
    ppn_t tablePpn;
    paddr_t pteAddr;
    logic [PteIndexWidth-1:0] pteIndex;
    logic [LineWidth-1:0] line;
    PageTableEntry pte;
    PageTableEntry updatedPte;
    logic isLeaf;
    logic isFault;
    logic permitted;
    ppn_t fillPpn;
    TlbEntryFlags fillFlags;

    assign levelOne = state inside {Idle, Read1, Decode1, Write1};
    assign pteAddr = levelOne ?
        {satp.PPN, missPage[19:10], {PteOffsetWidth{1'b0}}} :
        {tablePpn, missPage[9:0], {PteOffsetWidth{1'b0}}};
    assign pteIndex = pteAddr[PteOffsetWidth +: PteIndexWidth];

    assign isLeaf = pte.R || pte.X;
    assign isFault = !pte.V || (pte.W && !pte.R);

    always_comb begin
        case (missAccessType)
            Load:    permitted = pte.R;
            Store:   permitted = pte.W;
            default: permitted = pte.X;
        endcase
        updatedPte = pte;
        updatedPte.A = 1'b1;
        updatedPte.D = pte.D || (missAccessType == Store && permitted);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (enable) begin
                        state <= Read1;
                    end
                end
                Read1: begin
                    if (memReadDone) begin
                        state <= Decode1;
                    end
                end
                Decode1: begin
                    if (isFault) begin
                        state <= TlbWriteFault;
                    end else if (!isLeaf) begin
                        state <= Read0;
                    end else begin
                        state <= permitted ? Write1 : TlbWrite;
                    end
                end
                Read0: begin
                    if (memReadDone) begin
                        state <= Decode0;
                    end
                end
                Decode0: begin
                    // A pointer at level 0 has no next level
                    if (isFault || !isLeaf) begin
                        state <= TlbWriteFault;
                    end else begin
                        state <= permitted ? Write0 : TlbWrite;
                    end
                end
                Write1, Write0: begin
                    if (memWriteDone) begin
                        state <= TlbWrite;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (memReadDone) begin
            line <= memReadValue;
            pte <= memReadValue[pteIndex*PteWidth +: PteWidth];
        end
        if (state == Decode1) begin
            tablePpn <= {pte.PPN1, pte.PPN0};
            // Megapage keeps VPN0 as PPN0
            fillPpn <= {pte.PPN1, missPage[9:0]};
        end else if (state == Decode0) begin
            fillPpn <= {pte.PPN1, pte.PPN0};
        end
        if (state == Decode1 || state == Decode0) begin
            fillFlags.dirty <= updatedPte.D;
            fillFlags.user <= updatedPte.U;
            fillFlags.execute <= updatedPte.X;
            fillFlags.write <= updatedPte.W;
            fillFlags.read <= updatedPte.R;
        end
    end

    always_comb begin
        memWriteValue = line;
        memWriteValue[pteIndex*PteWidth +: PteWidth] = updatedPte;
    end

    assign memAddr = pteAddr[LineOffsetWidth +: MemAddrWidth];
    assign memReadEnable = state == Read1 || state == Read0;
    assign memWriteEnable = state == Write1 || state == Write0;

    assign done = state == TlbWrite || state == TlbWriteFault;
    assign tlbWriteEnable = done;
    assign tlbWriteKey = missPage;
    assign tlbWriteValue.valid = 1'b1;
    assign tlbWriteValue.fault = state == TlbWriteFault;
    assign tlbWriteValue.pageNumber = state == TlbWriteFault ? '0 : fillPpn;
    assign tlbWriteValue.flags = state == TlbWriteFault ? '0 : fillFlags;
endmodule

/* MemArbiter.sv */
// Walker has priority; a grant is held until the owner drops its enable
`timescale 1ns/1ps

module MemArbiter #(
    parameter int LineWidth = 128,
    parameter int MemAddrWidth = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [MemAddrWidth-1:0] walkMemAddr,
    input  logic                    walkMemReadEnable,
    input  logic                    walkMemWriteEnable,
    input  logic [LineWidth-1:0]    walkMemWriteValue,
    output logic                    walkMemReadDone,
    output logic                    walkMemWriteDone,
    output logic [LineWidth-1:0]    walkMemReadValue,
    input  logic [MemAddrWidth-1:0] dataMemAddr,
    input  logic                    dataMemReadEnable,
    input  logic                    dataMemWriteEnable,
    input  logic [LineWidth-1:0]    dataMemWriteValue,
    output logic                    dataMemReadDone,
    output logic                    dataMemWriteDone,
    output logic [LineWidth-1:0]    dataMemReadValue,
    output logic [MemAddrWidth-1:0] memAddr,
    output logic                    memReadEnable,
    output logic                    memWriteEnable,
    output logic [LineWidth-1:0]    memWriteValue,
    input  logic                    memReadDone,
    input  logic                    memWriteDone,
    input  logic [LineWidth-1:0]    memReadValue
);
    logic owner;
    logic walkActive;
    logic dataActive;
    logic grantData;

    assign walkActive = walkMemReadEnable || walkMemWriteEnable;
    assign dataActive = dataMemReadEnable || dataMemWriteEnable;
    // Keep the current owner while it is busy, otherwise walker first
    assign grantData = (owner ? dataActive : walkActive) ? owner : !walkActive;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= 1'b0;
        end else begin
            owner <= grantData;
        end
    end

    assign memAddr = grantData ? dataMemAddr : walkMemAddr;
    assign memReadEnable = grantData ? dataMemReadEnable : walkMemReadEnable;
    assign memWriteEnable = grantData ? dataMemWriteEnable : walkMemWriteEnable;
    assign memWriteValue = grantData ? dataMemWriteValue : walkMemWriteValue;

    assign walkMemReadDone = !grantData && memReadDone;
    assign walkMemWriteDone = !grantData && memWriteDone;
    assign dataMemReadDone = grantData && memReadDone;
    assign dataMemWriteDone = grantData && memWriteDone;
    assign walkMemReadValue = memReadValue;
    assign dataMemReadValue = memReadValue;
endmodule

/* LineMemory.sv */
// Fixed-latency line RAM; MemLatency must be at least 1
// Read and write enables must not be high together
`timescale 1ns/1ps

module LineMemory #(
    parameter int LineWidth = 128,
    parameter int MemAddrWidth = 10,
    parameter int MemLatency = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [MemAddrWidth-1:0] addr,
    input  logic                    readEnable,
    input  logic                    writeEnable,
    input  logic [LineWidth-1:0]    writeValue,
    output logic                    readDone,
    output logic                    writeDone,
    output logic [LineWidth-1:0]    readValue
);
    localparam int CountWidth = $clog2(MemLatency + 1);

    typedef logic [CountWidth-1:0] count_t;

    logic [LineWidth-1:0] lines [2**MemAddrWidth];
    count_t count;
    logic busy;
    logic finish;

    assign busy = readEnable || writeEnable;
    assign finish = busy && count == count_t'(MemLatency);
    assign readDone = readEnable && finish;
    assign writeDone = writeEnable && finish;

    always_ff @(posedge clk) begin
        if (rst || finish || !busy) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Address is held, so the registered read is current at done
    always_ff @(posedge clk) begin
        readValue <= lines[addr];
        if (writeDone) begin
            lines[addr] <= writeValue;
        end
    end
endmodule

/* MmuAccessUnit.sv */
// Word-aligned accesses only; no U-bit or privilege checks
// Upper physical address bits beyond the memory are dropped
`timescale 1ns/1ps

module MmuAccessUnit
    import MmuTypes::*;
#(
    parameter int LineWidth = 128,
    parameter int MemAddrWidth = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    reqValid,
    input  MmuRequest               req,
    output logic                    reqReady,
    output logic                    respValid,
    output MmuResponse              resp,
    input  SatpReg                  satp,
    output vpn_t                    lookupVpn,
    input  logic                    lookupHit,
    input  TlbEntry                 lookupEntry,
    output logic                    walkEnable,
    output vpn_t                    walkVpn,
    output AccessType               walkAccessType,
    input  logic                    walkDone,
    output logic [MemAddrWidth-1:0] memAddr,
    output logic                    memReadEnable,
    output logic                    memWriteEnable,
    output logic [LineWidth-1:0]    memWriteValue,
    input  logic                    memReadDone,
    input  logic                    memWriteDone,
    input  logic [LineWidth-1:0]    memReadValue
);
    localparam int WordWidth = $bits(word_t);
    localparam int WordIndexWidth = $clog2(LineWidth / WordWidth);
    localparam int LineOffsetWidth = $clog2(LineWidth / 8);

    typedef enum logic [2:0] {
        Idle,
        Lookup,
        Walk,
        Read,
        Write,
        Respond
    } State;

    State state;
    MmuRequest request;
    paddr_t paddr;
    logic [LineWidth-1:0] line;
    logic [LineWidth-1:0] mergedLine;
    word_t rdata;
    logic fault;
    logic [WordIndexWidth-1:0] wordIndex;
    logic isStore;
    logic permitted;

    assign isStore = request.accessType == Store;
    assign wordIndex = paddr[2 +: WordIndexWidth];

    always_comb begin
        case (request.accessType)
            Load:    permitted = lookupEntry.flags.read;
            Store:   permitted = lookupEntry.flags.write;
            default: permitted = lookupEntry.flags.execute;
        endcase
        mergedLine = memReadValue;
        mergedLine[wordIndex*WordWidth +: WordWidth] = request.wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (reqValid) begin
                        request <= req;
                        paddr <= paddr_t'(req.vaddr);
                        rdata <= '0;
                        fault <= 1'b0;
                        state <= satp.MODE ? Lookup : Read;
                    end
                end
                Lookup: begin
                    // First store to a clean writable page walks again to set D
                    if (!lookupHit || (isStore && !lookupEntry.fault &&
                            lookupEntry.flags.write && !lookupEntry.flags.dirty)) begin
                        state <= Walk;
                    end else if (lookupEntry.fault || !permitted) begin
                        fault <= 1'b1;
                        state <= Respond;
                    end else begin
                        paddr <= {lookupEntry.pageNumber, request.vaddr[PageOffsetWidth-1:0]};
                        state <= Read;
                    end
                end
                Walk: begin
                    if (walkDone) begin
                        state <= Lookup;
                    end
                end
                Read: begin
                    if (memReadDone) begin
                        line <= mergedLine;
                        rdata <= memReadValue[wordIndex*WordWidth +: WordWidth];
                        state <= isStore ? Write : Respond;
                    end
                end
                Write: begin
                    if (memWriteDone) begin
                        state <= Respond;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    assign reqReady = state == Idle;
    assign respValid = state == Respond;
    assign resp.rdata = rdata;
    assign resp.fault = fault;

    assign lookupVpn = request.vaddr[$bits(vaddr_t)-1:PageOffsetWidth];
    assign walkEnable = state == Walk;
    assign walkVpn = lookupVpn;
    assign walkAccessType = request.accessType;

    assign memAddr = paddr[LineOffsetWidth +: MemAddrWidth];
    assign memReadEnable = state == Read;
    assign memWriteEnable = state == Write;
    assign memWriteValue = line;
endmodule

/* MmuTop.sv */
// Sv32 MMU top; flush is only allowed while reqReady is high
`timescale 1ns/1ps

module MmuTop
    import MmuTypes::*;
#(
    parameter int LineWidth = 128,
    parameter int MemAddrWidth = 10,
    parameter int MemLatency = 2,
    parameter int TlbEntries = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       reqValid,
    input  MmuRequest  req,
    output logic       reqReady,
    output logic       respValid,
    output MmuResponse resp,
    input  SatpReg     satp,
    input  logic       flush
);
    vpn_t lookupVpn;
    logic lookupHit;
    TlbEntry lookupEntry;
    logic tlbWriteEnable;
    vpn_t tlbWriteKey;
    TlbEntry tlbWriteValue;
    logic walkEnable;
    vpn_t walkVpn;
    AccessType walkAccessType;
    logic walkDone;

    logic [MemAddrWidth-1:0] walkMemAddr;
    logic walkMemReadEnable;
    logic walkMemWriteEnable;
    logic [LineWidth-1:0] walkMemWriteValue;
    logic walkMemReadDone;
    logic walkMemWriteDone;
    logic [LineWidth-1:0] walkMemReadValue;
    logic [MemAddrWidth-1:0] dataMemAddr;
    logic dataMemReadEnable;
    logic dataMemWriteEnable;
    logic [LineWidth-1:0] dataMemWriteValue;
    logic dataMemReadDone;
    logic dataMemWriteDone;
    logic [LineWidth-1:0] dataMemReadValue;
    logic [MemAddrWidth-1:0] memAddr;
    logic memReadEnable;
    logic memWriteEnable;
    logic [LineWidth-1:0] memWriteValue;
    logic memReadDone;
    logic memWriteDone;
    logic [LineWidth-1:0] memReadValue;

    Tlb #(
        .TlbEntries(TlbEntries)
    ) Tlb_i (
        .clk(clk),
        .rst(rst),
        .lookupVpn(lookupVpn),
        .lookupHit(lookupHit),
        .lookupEntry(lookupEntry),
        .writeEnable(tlbWriteEnable),
        .writeKey(tlbWriteKey),
        .writeValue(tlbWriteValue),
        .flush(flush)
    );

    PageWalker #(
        .LineWidth(LineWidth),
        .MemAddrWidth(MemAddrWidth)
    ) PageWalker_i (
        .clk(clk),
        .rst(rst),
        .enable(walkEnable),
        .missPage(walkVpn),
        .missAccessType(walkAccessType),
        .satp(satp),
        .done(walkDone),
        .tlbWriteEnable(tlbWriteEnable),
        .tlbWriteKey(tlbWriteKey),
        .tlbWriteValue(tlbWriteValue),
        .memAddr(walkMemAddr),
        .memReadEnable(walkMemReadEnable),
        .memWriteEnable(walkMemWriteEnable),
        .memWriteValue(walkMemWriteValue),
        .memReadDone(walkMemReadDone),
        .memWriteDone(walkMemWriteDone),
        .memReadValue(walkMemReadValue)
    );

    MemArbiter #(
        .LineWidth(LineWidth),
        .MemAddrWidth(MemAddrWidth)
    ) MemArbiter_i (
        .*
    );

    LineMemory #(
        .LineWidth(LineWidth),
        .MemAddrWidth(MemAddrWidth),
        .MemLatency(MemLatency)
    ) LineMemory_i (
        .clk(clk),
        .rst(rst),
        .addr(memAddr),
        .readEnable(memReadEnable),
        .writeEnable(memWriteEnable),
        .writeValue(memWriteValue),
        .readDone(memReadDone),
        .writeDone(memWriteDone),
        .readValue(memReadValue)
    );

    MmuAccessUnit #(
        .LineWidth(LineWidth),
        .MemAddrWidth(MemAddrWidth)
    ) MmuAccessUnit_i (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .req(req),
        .reqReady(reqReady),
        .respValid(respValid),
        .resp(resp),
        .satp(satp),
        .lookupVpn(lookupVpn),
        .lookupHit(lookupHit),
        .lookupEntry(lookupEntry),
        .walkEnable(walkEnable),
        .walkVpn(walkVpn),
        .walkAccessType(walkAccessType),
        .walkDone(walkDone),
        .memAddr(dataMemAddr),
        .memReadEnable(dataMemReadEnable),
        .memWriteEnable(dataMemWriteEnable),
        .memWriteValue(dataMemWriteValue),
        .memReadDone(dataMemReadDone),
        .memWriteDone(dataMemWriteDone),
        .memReadValue(dataMemReadValue)
    );
endmodule

/* MmuTb.sv */
// Memory image layout assumes LineWidth 128 and MemAddrWidth 10
// Page tables live in pages 0 and 1, data pages are 2 and 3
`timescale 1ns/1ps

module MmuTb
    import MmuTypes::*;
();
    localparam int LineWidth = 128;
    localparam int MemAddrWidth = 10;
    localparam int MemLatency = 2;
    localparam int TlbEntries = 16;
    localparam int WordsPerLine = LineWidth / 32;
    localparam int ImageWords = (2**MemAddrWidth) * WordsPerLine;
    localparam int ResetCycles = 16;
    localparam int BareCount = 12;
    localparam int RequestCount = 2 * BareCount + 25;
    localparam int CyclesPerRequest = 200;
    localparam ppn_t RootPpn = 22'd0;
    localparam logic [7:0] PteV = 8'h01;
    localparam logic [7:0] PteR = 8'h02;
    localparam logic [7:0] PteW = 8'h04;
    localparam logic [7:0] PteX = 8'h08;
    localparam logic [7:0] PteA = 8'h40;

    typedef logic [LineWidth-1:0] line_t;

    typedef struct packed {
        logic  checkData;
        logic  fault;
        word_t rdata;
    } Expectation;

    logic clk;
    logic rst;
    logic reqValid;
    MmuRequest req;
    logic reqReady;
    logic respValid;
    MmuResponse resp;
    SatpReg satp;
    logic flush;

    word_t seed;
    word_t image [ImageWords];
    Expectation pending [$];

    // TLB model, direct mapped like the DUT
    logic tlbValid [TlbEntries];
    vpn_t tlbKey [TlbEntries];
    logic tlbFault [TlbEntries];
    ppn_t tlbPpn [TlbEntries];
    PageTableEntry tlbPte [TlbEntries];

    MmuTop #(
        .LineWidth(LineWidth),
        .MemAddrWidth(MemAddrWidth),
        .MemLatency(MemLatency),
        .TlbEntries(TlbEntries)
    ) MmuTop_i (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .req(req),
        .reqReady(reqReady),
        .respValid(respValid),
        .resp(resp),
        .satp(satp),
        .flush(flush)
    );

    always #20 clk = ~clk;

    function automatic word_t nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t makePte(ppn_t ppn, logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic vaddr_t virtualAddress(logic [9:0] vpn1, logic [9:0] vpn0,
            word_t offsetSource);
        return {vpn1, vpn0, offsetSource[11:2], 2'b00};
    endfunction

    function automatic int imageIndex(paddr_t pa);
        return int'(pa[MemAddrWidth+3:2]);
    endfunction

    function automatic logic permits(PageTableEntry pte, AccessType kind);
        case (kind)
            Load:    return pte.R;
            Store:   return pte.W;
            default: return pte.X;
        endcase
    endfunction

    function automatic void clearTlbModel();
        for (int i = 0; i < TlbEntries; i++) begin
            tlbValid[i] = 1'b0;
        end
    endfunction

    // Sv32 walk on the image; A/D only change when the leaf allows the access
    function automatic void walkTables(vpn_t vpn, AccessType kind);
        paddr_t pteAddr;
        PageTableEntry pte;
        logic fault;
        ppn_t ppn;
        int idx;
        idx = int'(vpn) % TlbEntries;
        pteAddr = {RootPpn, vpn[19:10], 2'b00};
        pte = image[imageIndex(pteAddr)];
        fault = !pte.V || (pte.W && !pte.R);
        ppn = {pte.PPN1, vpn[9:0]};
        if (!fault && !(pte.R || pte.X)) begin
            pteAddr = {pte.PPN1, pte.PPN0, vpn[9:0], 2'b00};
            pte = image[imageIndex(pteAddr)];
            fault = !pte.V || (pte.W && !pte.R) || !(pte.R || pte.X);
            ppn = {pte.PPN1, pte.PPN0};
        end
        if (!fault && permits(pte, kind)) begin
            pte.A = 1'b1;
            if (kind == Store) begin
                pte.D = 1'b1;
            end
            image[imageIndex(pteAddr)] = pte;
        end
        tlbValid[idx] = 1'b1;
        tlbKey[idx] = vpn;
        tlbFault[idx] = fault;
        tlbPpn[idx] = ppn;
        tlbPte[idx] = pte;
    endfunction

    function automatic Expectation expectedResponse(AccessType kind, vaddr_t va,
            word_t wdata, logic bare);
        Expectation e;
        paddr_t pa;
        vpn_t vpn;
        int idx;
        vpn = va[31:12];
        idx = int'(vpn) % TlbEntries;
        e.checkData = kind != Store;
        e.fault = 1'b0;
        pa = paddr_t'(va);
        if (!bare) begin
            if (!(tlbValid[idx] && tlbKey[idx] == vpn) || (kind == Store &&
                    !tlbFault[idx] && tlbPte[idx].W && !tlbPte[idx].D)) begin
                walkTables(vpn, kind);
            end
            if (tlbFault[idx] || !permits(tlbPte[idx], kind)) begin
                e.fault = 1'b1;
                e.checkData = 1'b0;
                e.rdata = '0;
                return e;
            end
            pa = {tlbPpn[idx], va[11:0]};
        end
        e.rdata = image[imageIndex(pa)];
        if (kind == Store) begin
            image[imageIndex(pa)] = wdata;
        end
        return e;
    endfunction

    task automatic check(string name, line_t actual, line_t expectedValue);
        if (actual !== expectedValue) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expectedValue);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic loadImage();
        for (int i = 0; i < ImageWords; i++) begin
            image[i] = {4'ha, 12'(i), 4'h5, ~12'(i)};
        end
        // Root table: VPN1 1 points to the level-0 table, VPN1 2 is a megapage
        image[1] = makePte(22'd1, PteV);
        image[2] = makePte({12'h5, 10'h0}, PteV | PteR | PteX);
        image[1024] = makePte(22'd2, PteV | PteR | PteW);
        image[1025] = makePte(22'd3, PteV | PteR);
        image[1027] = '0;
        image[1028] = makePte(22'd3, PteV | PteW);
        image[1029] = makePte(22'd2, PteV);
        image[1030] = makePte(22'd3, PteV | PteR | PteW);
        image[1031] = makePte(22'd2, PteV | PteR);
        for (int i = 0; i < 2**MemAddrWidth; i++) begin
            MmuTop_i.LineMemory_i.lines[i] =
                {image[4*i+3], image[4*i+2], image[4*i+1], image[4*i]};
        end
        clearTlbModel();
    endtask

    task automatic compareImage();
        for (int i = 0; i < 2**MemAddrWidth; i++) begin
            check($sformatf("lines[%0d]", i), MmuTop_i.LineMemory_i.lines[i],
                {image[4*i+3], image[4*i+2], image[4*i+1], image[4*i]});
        end
    endtask

    // Returns in the response cycle, while resp still holds the answer
    task automatic issue(AccessType kind, vaddr_t va, word_t wdata, logic bare);
        pending.push_back(expectedResponse(kind, va, wdata, bare));
        @(posedge clk);
        #1;
        satp.MODE = !bare;
        req.accessType = kind;
        req.vaddr = va;
        req.wdata = wdata;
        reqValid = 1'b1;
        while (!reqReady) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        reqValid = 1'b0;
        while (!respValid) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic flushTlb();
        @(posedge clk);
        #1;
        flush = 1'b1;
        clearTlbModel();
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    always @(negedge clk) begin : compareResponses
        Expectation e;
        if (!rst && respValid) begin
            if (pending.size() == 0) begin
                $display("A response arrived with no request outstanding");
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                e = pending.pop_front();
                check("resp.fault", line_t'(resp.fault), line_t'(e.fault));
                if (e.checkData) begin
                    check("resp.rdata", line_t'(resp.rdata), line_t'(e.rdata));
                end
            end
        end
    end

    initial begin
        repeat (ResetCycles + RequestCount * CyclesPerRequest) @(posedge clk);
        $display("Timed out before all requests were answered");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        vaddr_t addrs [BareCount];
        vaddr_t va;
        word_t r;
        PageTableEntry pte;
        clk = 1'b0;
        rst = 1'b1;
        reqValid = 1'b0;
        req = '0;
        satp = '0;
        satp.PPN = RootPpn;
        flush = 1'b0;
        seed = 32'hb1b3_bf1b;
        loadImage();
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        // Bare mode stores then loads in pages 2 and 3
        for (int i = 0; i < BareCount; i++) begin
            addrs[i] = 32'h2000 | (nextRandom() & 32'h1ffc);
            issue(Store, addrs[i], nextRandom(), 1'b1);
        end
        for (int i = 0; i < BareCount; i++) begin
            issue(Load, addrs[i], '0, 1'b1);
        end

        // Two-level walk on a 4 KiB page
        for (int i = 0; i < 3; i++) begin
            issue(Load, virtualAddress(10'd1, 10'd0, nextRandom()), '0, 1'b0);
        end
        issue(Load, 32'h1000, '0, 1'b1);
        pte = resp.rdata;
        check("leaf PTE A", line_t'(pte.A), line_t'(1'b1));
        check("leaf PTE D", line_t'(pte.D), line_t'(1'b0));

        // Store hitting a clean TLB entry, then a cold store
        va = virtualAddress(10'd1, 10'd0, nextRandom());
        issue(Store, va, nextRandom(), 1'b0);
        issue(Load, va, '0, 1'b0);
        va = virtualAddress(10'd1, 10'd6, nextRandom());
        issue(Store, va, nextRandom(), 1'b0);
        issue(Load, va, '0, 1'b0);
        issue(Load, 32'h1000, '0, 1'b1);
        pte = resp.rdata;
        check("clean hit PTE D", line_t'(pte.D), line_t'(1'b1));
        issue(Load, 32'h1018, '0, 1'b1);
        pte = resp.rdata;
        check("cold store PTE D", line_t'(pte.D), line_t'(1'b1));

        // Megapage at level 1
        for (int i = 0; i < 6; i++) begin
            r = nextRandom();
            issue(Load, virtualAddress(10'd2, r[21:12], r), '0, 1'b0);
        end

        // Faults
        issue(Load, virtualAddress(10'd1, 10'd3, '0), '0, 1'b0);
        issue(Load, virtualAddress(10'd1, 10'd4, '0), '0, 1'b0);
        issue(Load, virtualAddress(10'd1, 10'd5, '0), '0, 1'b0);
        r = nextRandom();
        issue(Store, virtualAddress(10'd1, 10'd1, r), nextRandom(), 1'b0);
        issue(Fetch, virtualAddress(10'd1, 10'd1, r), '0, 1'b0);

        // Stale translation until the flush
        va = virtualAddress(10'd1, 10'd7, nextRandom());
        issue(Load, va, '0, 1'b0);
        issue(Store, 32'h101c, makePte(22'd3, PteV | PteR | PteA), 1'b1);
        issue(Load, va, '0, 1'b0);
        flushTlb();
        issue(Load, va, '0, 1'b0);

        @(posedge clk);
        #1;
        compareImage();
        if (pending.size() != 0) begin
            $display("%0d responses never arrived", pending.size());
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end
endmodule

/* all.f */
MmuTypes.sv
Tlb.sv
PageWalker.sv
MemArbiter.sv
LineMemory.sv
MmuAccessUnit.sv
MmuTop.sv
MmuTb.sv

/* run.sh */
#!/bin/sh
# Builds the MMU testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f all.f --top-module MmuTb -o MmuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/MmuSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
